//--- include/tinyrv1_defines.svh
`ifndef TINYRV1_DEFINES_SVH
`define TINYRV1_DEFINES_SVH

// ==================================================
// Instruction match patterns
// ==================================================

`define ADD  32'b0000000_?????_?????_000_?????_0110011
`define ADDI 32'b???????_?????_?????_000_?????_0010011
`define MUL  32'b0000001_?????_?????_000_?????_0110011
`define LW   32'b???????_?????_?????_010_?????_0000011
`define SW   32'b???????_?????_?????_010_?????_0100011
`define JAL  32'b???????_?????_?????_???_?????_1101111
`define JR   32'b0000000_00000_?????_000_00000_1100111
`define BNE  32'b???????_?????_?????_001_?????_1100011
`define CSRR 32'b???????_?????_00000_010_?????_1110011
`define CSRW 32'b???????_?????_?????_001_00000_1110011

// Field ranges
`define RS1 19:15
`define RS2 24:20
`define RD  11:7
`define CSR 31:20

// CSR numbers
`define CSR_IN0  12'hfc2
`define CSR_IN1  12'hfc3
`define CSR_IN2  12'hfc4
`define CSR_OUT0 12'h7c2
`define CSR_OUT1 12'h7c3
`define CSR_OUT2 12'h7c4

// First fetch address
`define RESET_PC 32'h0000_0200

`endif

//--- hdl/tinyrv1_pkg.sv
package tinyrv1_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [1:0]  pc_sel_t;
  typedef logic [1:0]  byp_sel_t;
  typedef logic [1:0]  imm_type_t;
  typedef logic [1:0]  op2_sel_t;
  typedef logic [1:0]  result_sel_t;
  typedef logic [1:0]  csr_sel_t;

  // Next PC source
  localparam pc_sel_t PC_PLUS4 = 2'd0;
  localparam pc_sel_t PC_JR    = 2'd1;
  localparam pc_sel_t PC_JAL   = 2'd2;
  localparam pc_sel_t PC_BR    = 2'd3;

  // Operand source
  localparam byp_sel_t BYP_RF = 2'd0;
  localparam byp_sel_t BYP_X  = 2'd1;
  localparam byp_sel_t BYP_M  = 2'd2;
  localparam byp_sel_t BYP_W  = 2'd3;

  // Immediate formats
  localparam imm_type_t IMM_I = 2'd0;
  localparam imm_type_t IMM_S = 2'd1;
  localparam imm_type_t IMM_J = 2'd2;
  localparam imm_type_t IMM_B = 2'd3;

  // Second operand
  // Zero lets CSRW pass rs1 through the adder
  localparam op2_sel_t OP2_RF   = 2'd0;
  localparam op2_sel_t OP2_IMM  = 2'd1;
  localparam op2_sel_t OP2_FOUR = 2'd2;
  localparam op2_sel_t OP2_ZERO = 2'd3;

  // Execute result
  localparam result_sel_t RES_ALU = 2'd0;
  localparam result_sel_t RES_MUL = 2'd1;
  localparam result_sel_t RES_CSR = 2'd2;

endpackage

//--- hdl/pipe_ctrl.sv
`timescale 1ns/100ps

`include "tinyrv1_defines.svh"

module pipe_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  tinyrv1_pkg::word_t       inst_d,
  input  logic                     eq_x,
  output logic                     reg_en_f,
  output logic                     reg_en_d,
  output tinyrv1_pkg::pc_sel_t     pc_sel,
  output tinyrv1_pkg::imm_type_t   imm_type,
  output tinyrv1_pkg::byp_sel_t    op1_byp_sel,
  output tinyrv1_pkg::byp_sel_t    op2_byp_sel,
  output logic                     op1_sel,
  output tinyrv1_pkg::op2_sel_t    op2_sel,
  output tinyrv1_pkg::csr_sel_t    csr_sel,
  output logic                     alu_fn,
  output tinyrv1_pkg::result_sel_t result_sel,
  output logic                     dmem_val,
  output logic                     dmem_type,
  output logic                     wb_sel,
  output logic                     rf_wen,
  output tinyrv1_pkg::reg_addr_t   rf_waddr,
  output logic [2:0]               csrw_en
);

  tinyrv1_pkg::word_t     inst_x;
  tinyrv1_pkg::word_t     inst_m;
  tinyrv1_pkg::word_t     inst_w;
  logic                   val_d;
  logic                   val_x;
  logic                   val_m;
  logic                   val_w;
  tinyrv1_pkg::reg_addr_t rs1_addr;
  tinyrv1_pkg::reg_addr_t rs2_addr;
  logic                   rs1_en_d;
  logic                   rs2_en_d;
  logic                   dep1_x;
  logic                   dep1_m;
  logic                   dep1_w;
  logic                   dep2_x;
  logic                   dep2_m;
  logic                   dep2_w;
  logic                   lw_x;
  logic                   stall_d;
  logic                   squash_d;
  logic                   squash_f;

  function automatic logic writes_rd(input tinyrv1_pkg::word_t inst);
    return (inst ==? `ADD) | (inst ==? `ADDI) | (inst ==? `MUL) |
           (inst ==? `LW)  | (inst ==? `JAL)  | (inst ==? `CSRR);
  endfunction

  // Older instruction in flight that writes the given source register
  function automatic logic dep(input logic src_val, input tinyrv1_pkg::word_t src_inst,
                               input tinyrv1_pkg::reg_addr_t rs);
    return src_val & writes_rd(src_inst) & (src_inst[`RD] == rs) & (src_inst[`RD] != 5'd0);
  endfunction

  // Youngest producer wins
  function automatic tinyrv1_pkg::byp_sel_t byp_pick(input logic hit_x, input logic hit_m,
                                                     input logic hit_w);
    if (hit_x) return tinyrv1_pkg::BYP_X;
    if (hit_m) return tinyrv1_pkg::BYP_M;
    if (hit_w) return tinyrv1_pkg::BYP_W;
    return tinyrv1_pkg::BYP_RF;
  endfunction

  // ==================================================
  // Instruction and valid registers
  // ==================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_x <= '0;
      inst_m <= '0;
      inst_w <= '0;
      val_d  <= 1'b0;
      val_x  <= 1'b0;
      val_m  <= 1'b0;
      val_w  <= 1'b0;
    end else begin
      inst_x <= inst_d;
      inst_m <= inst_x;
      inst_w <= inst_m;
      // A stalled D slot keeps its instruction
      val_d  <= stall_d | ~squash_f;
      val_x  <= val_d & ~stall_d & ~squash_d;
      val_m  <= val_x;
      val_w  <= val_m;
    end
  end

  // ==================================================
  // Hazards
  // ==================================================

  assign rs1_addr = inst_d[`RS1];
  assign rs2_addr = inst_d[`RS2];

  always_comb begin
    rs1_en_d = val_d & ((inst_d ==? `ADD) | (inst_d ==? `ADDI) | (inst_d ==? `MUL) |
                        (inst_d ==? `LW)  | (inst_d ==? `SW)   | (inst_d ==? `JR)  |
                        (inst_d ==? `BNE) | (inst_d ==? `CSRW));
    rs2_en_d = val_d & ((inst_d ==? `ADD) | (inst_d ==? `MUL) |
                        (inst_d ==? `SW)  | (inst_d ==? `BNE));
    dep1_x = rs1_en_d & dep(val_x, inst_x, rs1_addr);
    dep1_m = rs1_en_d & dep(val_m, inst_m, rs1_addr);
    dep1_w = rs1_en_d & dep(val_w, inst_w, rs1_addr);
    dep2_x = rs2_en_d & dep(val_x, inst_x, rs2_addr);
    dep2_m = rs2_en_d & dep(val_m, inst_m, rs2_addr);
    dep2_w = rs2_en_d & dep(val_w, inst_w, rs2_addr);
  end

  // Load data is not ready until M
  assign lw_x    = val_x & (inst_x ==? `LW);
  assign stall_d = lw_x & (dep1_x | dep2_x);

  assign op1_byp_sel = byp_pick(dep1_x & ~lw_x, dep1_m, dep1_w);
  assign op2_byp_sel = byp_pick(dep2_x & ~lw_x, dep2_m, dep2_w);

  // Taken branch kills D and F, jumps kill F only
  assign squash_d = val_x & (inst_x ==? `BNE) & ~eq_x;
  assign squash_f = squash_d | (val_d & ~stall_d & ((inst_d ==? `JAL) | (inst_d ==? `JR)));

  assign reg_en_f = ~stall_d;
  assign reg_en_d = ~stall_d;

  // ==================================================
  // Fetch and decode control
  // ==================================================

  always_comb begin
    pc_sel = tinyrv1_pkg::PC_PLUS4;
    if (squash_d) begin
      pc_sel = tinyrv1_pkg::PC_BR;
    end else if (val_d) begin
      casez (inst_d)
        `JR:     pc_sel = tinyrv1_pkg::PC_JR;
        `JAL:    pc_sel = tinyrv1_pkg::PC_JAL;
        default: pc_sel = tinyrv1_pkg::PC_PLUS4;
      endcase
    end
  end

  task automatic cs_d(input tinyrv1_pkg::imm_type_t imm, input logic op1,
                      input tinyrv1_pkg::op2_sel_t op2);
    imm_type = imm;
    op1_sel  = op1;
    op2_sel  = op2;
  endtask

  always_comb begin
    casez (inst_d)
      //               imm                     op1   op2
      `ADDI:   cs_d(tinyrv1_pkg::IMM_I, 1'b0, tinyrv1_pkg::OP2_IMM);
      `LW:     cs_d(tinyrv1_pkg::IMM_I, 1'b0, tinyrv1_pkg::OP2_IMM);
      `SW:     cs_d(tinyrv1_pkg::IMM_S, 1'b0, tinyrv1_pkg::OP2_IMM);
      `JAL:    cs_d(tinyrv1_pkg::IMM_J, 1'b1, tinyrv1_pkg::OP2_FOUR);
      `BNE:    cs_d(tinyrv1_pkg::IMM_B, 1'b0, tinyrv1_pkg::OP2_RF);
      `CSRW:   cs_d(tinyrv1_pkg::IMM_I, 1'b0, tinyrv1_pkg::OP2_ZERO);
      default: cs_d(tinyrv1_pkg::IMM_I, 1'b0, tinyrv1_pkg::OP2_RF);
    endcase
  end

  // ==================================================
  // Execute, memory and writeback control
  // ==================================================

  always_comb begin
    alu_fn     = 1'b0;
    result_sel = tinyrv1_pkg::RES_ALU;
    if (val_x) begin
      casez (inst_x)
        `MUL:    result_sel = tinyrv1_pkg::RES_MUL;
        `CSRR:   result_sel = tinyrv1_pkg::RES_CSR;
        `BNE:    alu_fn = 1'b1;
        default: result_sel = tinyrv1_pkg::RES_ALU;
      endcase
    end
  end

  always_comb begin
    csr_sel = 2'd0;
    if (val_x && (inst_x ==? `CSRR)) begin
      case (inst_x[`CSR])
        `CSR_IN0: csr_sel = 2'd0;
        `CSR_IN1: csr_sel = 2'd1;
        `CSR_IN2: csr_sel = 2'd2;
        default:  csr_sel = 2'd0;
      endcase
    end
  end

  // Loads return data in M and take the memory path
  assign dmem_val  = val_m & ((inst_m ==? `LW) | (inst_m ==? `SW));
  assign dmem_type = val_m & (inst_m ==? `SW);
  assign wb_sel    = val_m & (inst_m ==? `LW);

  assign rf_wen   = val_w & writes_rd(inst_w);
  assign rf_waddr = val_w ? inst_w[`RD] : 5'd0;

  always_comb begin
    csrw_en = 3'b000;
    if (val_w && (inst_w ==? `CSRW)) begin
      case (inst_w[`CSR])
        `CSR_OUT0: csrw_en = 3'b001;
        `CSR_OUT1: csrw_en = 3'b010;
        `CSR_OUT2: csrw_en = 3'b100;
        default:   csrw_en = 3'b000;
      endcase
    end
  end

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/100ps

`include "tinyrv1_defines.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  tinyrv1_pkg::word_t     imem_data,
  input  tinyrv1_pkg::pc_sel_t   pc_sel,
  input  logic                   reg_en_f,
  input  logic                   reg_en_d,
  input  tinyrv1_pkg::imm_type_t imm_type,
  input  tinyrv1_pkg::byp_sel_t  op1_byp_sel,
  input  tinyrv1_pkg::byp_sel_t  op2_byp_sel,
  input  logic                   op1_sel,
  input  tinyrv1_pkg::op2_sel_t  op2_sel,
  input  tinyrv1_pkg::word_t     result_x,
  input  tinyrv1_pkg::word_t     result_m,
  input  tinyrv1_pkg::word_t     result_w,
  input  tinyrv1_pkg::word_t     rf_wdata,
  input  logic                   rf_wen,
  input  tinyrv1_pkg::reg_addr_t rf_waddr,
  output tinyrv1_pkg::word_t     imem_addr,
  output tinyrv1_pkg::word_t     inst_d,
  output tinyrv1_pkg::word_t     op1_x,
  output tinyrv1_pkg::word_t     op2_x,
  output tinyrv1_pkg::word_t     store_x,
  output tinyrv1_pkg::word_t     pc_x
);

  tinyrv1_pkg::word_t pc_f;
  tinyrv1_pkg::word_t pc_next;
  tinyrv1_pkg::word_t pc_d;
  tinyrv1_pkg::word_t rf_mem [0:31];
  tinyrv1_pkg::word_t rs1_rf;
  tinyrv1_pkg::word_t rs2_rf;
  tinyrv1_pkg::word_t rs1_d;
  tinyrv1_pkg::word_t rs2_d;
  tinyrv1_pkg::word_t imm_d;
  tinyrv1_pkg::word_t op1_d;
  tinyrv1_pkg::word_t op2_d;
  tinyrv1_pkg::word_t jal_target_d;
  tinyrv1_pkg::word_t imm_x;
  tinyrv1_pkg::word_t br_target_x;

  function automatic tinyrv1_pkg::word_t byp_mux(
    input tinyrv1_pkg::byp_sel_t sel,
    input tinyrv1_pkg::word_t    rf_val,
    input tinyrv1_pkg::word_t    x_val,
    input tinyrv1_pkg::word_t    m_val,
    input tinyrv1_pkg::word_t    w_val
  );
    case (sel)
      tinyrv1_pkg::BYP_X: return x_val;
      tinyrv1_pkg::BYP_M: return m_val;
      tinyrv1_pkg::BYP_W: return w_val;
      default:            return rf_val;
    endcase
  endfunction

  // ==================================================
  // Fetch
  // ==================================================

  always_comb begin
    case (pc_sel)
      tinyrv1_pkg::PC_JR:  pc_next = rs1_d;
      tinyrv1_pkg::PC_JAL: pc_next = jal_target_d;
      tinyrv1_pkg::PC_BR:  pc_next = br_target_x;
      default:             pc_next = pc_f + 32'd4;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_f   <= `RESET_PC;
      inst_d <= '0;
    end else if (reg_en_f) begin
      pc_f   <= pc_next;
      inst_d <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_en_f) begin
      pc_d <= pc_f;
    end
  end

  assign imem_addr = pc_f;

  // ==================================================
  // Register file and operands
  // ==================================================

  always_ff @(posedge clk) begin
    if (rf_wen && (rf_waddr != 5'd0)) begin
      rf_mem[rf_waddr] <= rf_wdata;
    end
  end

  // x0 reads as zero
  assign rs1_rf = (inst_d[`RS1] == 5'd0) ? '0 : rf_mem[inst_d[`RS1]];
  assign rs2_rf = (inst_d[`RS2] == 5'd0) ? '0 : rf_mem[inst_d[`RS2]];

  assign rs1_d = byp_mux(op1_byp_sel, rs1_rf, result_x, result_m, result_w);
  assign rs2_d = byp_mux(op2_byp_sel, rs2_rf, result_x, result_m, result_w);

  always_comb begin
    case (imm_type)
      tinyrv1_pkg::IMM_S: imm_d = {{20{inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
      tinyrv1_pkg::IMM_J: imm_d = {{12{inst_d[31]}}, inst_d[19:12], inst_d[20],
                                   inst_d[30:21], 1'b0};
      tinyrv1_pkg::IMM_B: imm_d = {{20{inst_d[31]}}, inst_d[7], inst_d[30:25],
                                   inst_d[11:8], 1'b0};
      default:            imm_d = {{20{inst_d[31]}}, inst_d[31:20]};
    endcase
  end

  assign jal_target_d = pc_d + imm_d;
  assign op1_d        = op1_sel ? pc_d : rs1_d;

  always_comb begin
    case (op2_sel)
      tinyrv1_pkg::OP2_IMM:  op2_d = imm_d;
      tinyrv1_pkg::OP2_FOUR: op2_d = 32'd4;
      tinyrv1_pkg::OP2_ZERO: op2_d = '0;
      default:               op2_d = rs2_d;
    endcase
  end

  // D to X
  always_ff @(posedge clk) begin
    if (reg_en_d) begin
      op1_x   <= op1_d;
      op2_x   <= op2_d;
      store_x <= rs2_d;
      pc_x    <= pc_d;
      imm_x   <= imm_d;
    end
  end

  // BNE target resolved alongside the compare in X
  assign br_target_x = pc_x + imm_x;

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  tinyrv1_pkg::word_t       op1_x,
  input  tinyrv1_pkg::word_t       op2_x,
  input  tinyrv1_pkg::word_t       store_x,
  input  tinyrv1_pkg::word_t       csr_in0,
  input  tinyrv1_pkg::word_t       csr_in1,
  input  tinyrv1_pkg::word_t       csr_in2,
  input  logic                     alu_fn,
  input  tinyrv1_pkg::result_sel_t result_sel,
  input  tinyrv1_pkg::csr_sel_t    csr_sel,
  output logic                     eq_x,
  output tinyrv1_pkg::word_t       result_x,
  output tinyrv1_pkg::word_t       result_m_raw,
  output tinyrv1_pkg::word_t       store_m
);

  tinyrv1_pkg::word_t alu_x;
  tinyrv1_pkg::word_t mul_x;
  tinyrv1_pkg::word_t csr_x;

  assign eq_x = (op1_x == op2_x);

  // Adder, or compare flag for BNE
  assign alu_x = alu_fn ? {31'd0, eq_x} : op1_x + op2_x;

  // Low half of the product
  assign mul_x = op1_x * op2_x;

  always_comb begin
    case (csr_sel)
      2'd1:    csr_x = csr_in1;
      2'd2:    csr_x = csr_in2;
      default: csr_x = csr_in0;
    endcase
  end

  always_comb begin
    case (result_sel)
      tinyrv1_pkg::RES_MUL: result_x = mul_x;
      tinyrv1_pkg::RES_CSR: result_x = csr_x;
      default:              result_x = alu_x;
    endcase
  end

  // X to M
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_m_raw <= '0;
      store_m      <= '0;
    end else begin
      result_m_raw <= result_x;
      store_m      <= store_x;
    end
  end

endmodule

//--- hdl/result_stage.sv
`timescale 1ns/100ps

module result_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  tinyrv1_pkg::word_t result_m_raw,
  input  tinyrv1_pkg::word_t store_m,
  input  tinyrv1_pkg::word_t dmem_rdata,
  input  logic               dmem_val,
  input  logic               dmem_type,
  input  logic               wb_sel,
  input  logic [2:0]         csrw_en,
  output logic               dmem_val_o,
  output logic               dmem_type_o,
  output tinyrv1_pkg::word_t dmem_addr,
  output tinyrv1_pkg::word_t dmem_wdata,
  output tinyrv1_pkg::word_t result_m,
  output tinyrv1_pkg::word_t result_w,
  output tinyrv1_pkg::word_t rf_wdata,
  output tinyrv1_pkg::word_t out0,
  output tinyrv1_pkg::word_t out1,
  output tinyrv1_pkg::word_t out2,
  output logic [2:0]         out_en
);

  // Memory request
  // Address comes from the adder
  assign dmem_val_o  = dmem_val;
  assign dmem_type_o = dmem_type;
  assign dmem_addr   = result_m_raw;
  assign dmem_wdata  = store_m;

  assign result_m = wb_sel ? dmem_rdata : result_m_raw;

  // M to W
  always_ff @(posedge clk) begin
    result_w <= result_m;
  end

  assign rf_wdata = result_w;

  // ==================================================
  // CSR outputs
  // ==================================================

  // Value and strobe appear together the cycle after W
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out0   <= '0;
      out1   <= '0;
      out2   <= '0;
      out_en <= 3'b000;
    end else begin
      out_en <= csrw_en;
      if (csrw_en[0]) begin
        out0 <= result_w;
      end
      if (csrw_en[1]) begin
        out1 <= result_w;
      end
      if (csrw_en[2]) begin
        out2 <= result_w;
      end
    end
  end

endmodule

//--- hdl/tinyrv1_proc.sv
`timescale 1ns/100ps

module tinyrv1_proc (
  input  logic               clk,
  input  logic               rst_n,
  output tinyrv1_pkg::word_t imem_addr,
  input  tinyrv1_pkg::word_t imem_data,
  output logic               dmem_val,
  output logic               dmem_type,
  output tinyrv1_pkg::word_t dmem_addr,
  output tinyrv1_pkg::word_t dmem_wdata,
  input  tinyrv1_pkg::word_t dmem_rdata,
  input  tinyrv1_pkg::word_t csr_in0,
  input  tinyrv1_pkg::word_t csr_in1,
  input  tinyrv1_pkg::word_t csr_in2,
  output tinyrv1_pkg::word_t out0,
  output tinyrv1_pkg::word_t out1,
  output tinyrv1_pkg::word_t out2,
  output logic [2:0]         out_en
);

  // Control to datapath
  logic                     reg_en_f;
  logic                     reg_en_d;
  tinyrv1_pkg::pc_sel_t     pc_sel;
  tinyrv1_pkg::imm_type_t   imm_type;
  tinyrv1_pkg::byp_sel_t    op1_byp_sel;
  tinyrv1_pkg::byp_sel_t    op2_byp_sel;
  logic                     op1_sel;
  tinyrv1_pkg::op2_sel_t    op2_sel;
  tinyrv1_pkg::csr_sel_t    csr_sel;
  logic                     alu_fn;
  tinyrv1_pkg::result_sel_t result_sel;
  logic                     dmem_val_m;
  logic                     dmem_type_m;
  logic                     wb_sel;
  logic                     rf_wen;
  tinyrv1_pkg::reg_addr_t   rf_waddr;
  logic [2:0]               csrw_en;

  // Status and datapath
  tinyrv1_pkg::word_t inst_d;
  logic               eq_x;
  tinyrv1_pkg::word_t op1_x;
  tinyrv1_pkg::word_t op2_x;
  tinyrv1_pkg::word_t store_x;
  tinyrv1_pkg::word_t result_x;
  tinyrv1_pkg::word_t result_m_raw;
  tinyrv1_pkg::word_t store_m;
  tinyrv1_pkg::word_t result_m;
  tinyrv1_pkg::word_t result_w;
  tinyrv1_pkg::word_t rf_wdata;

  pipe_ctrl pipe_ctrl_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_d     (inst_d),
    .eq_x       (eq_x),
    .reg_en_f   (reg_en_f),
    .reg_en_d   (reg_en_d),
    .pc_sel     (pc_sel),
    .imm_type   (imm_type),
    .op1_byp_sel(op1_byp_sel),
    .op2_byp_sel(op2_byp_sel),
    .op1_sel    (op1_sel),
    .op2_sel    (op2_sel),
    .csr_sel    (csr_sel),
    .alu_fn     (alu_fn),
    .result_sel (result_sel),
    .dmem_val   (dmem_val_m),
    .dmem_type  (dmem_type_m),
    .wb_sel     (wb_sel),
    .rf_wen     (rf_wen),
    .rf_waddr   (rf_waddr),
    .csrw_en    (csrw_en)
  );

  // Branch target is formed inside the decode block
  decode_stage decode_stage_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_data  (imem_data),
    .pc_sel     (pc_sel),
    .reg_en_f   (reg_en_f),
    .reg_en_d   (reg_en_d),
    .imm_type   (imm_type),
    .op1_byp_sel(op1_byp_sel),
    .op2_byp_sel(op2_byp_sel),
    .op1_sel    (op1_sel),
    .op2_sel    (op2_sel),
    .result_x   (result_x),
    .result_m   (result_m),
    .result_w   (result_w),
    .rf_wdata   (rf_wdata),
    .rf_wen     (rf_wen),
    .rf_waddr   (rf_waddr),
    .imem_addr  (imem_addr),
    .inst_d     (inst_d),
    .op1_x      (op1_x),
    .op2_x      (op2_x),
    .store_x    (store_x),
    .pc_x       ()
  );

  execute_stage execute_stage_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .op1_x       (op1_x),
    .op2_x       (op2_x),
    .store_x     (store_x),
    .csr_in0     (csr_in0),
    .csr_in1     (csr_in1),
    .csr_in2     (csr_in2),
    .alu_fn      (alu_fn),
    .result_sel  (result_sel),
    .csr_sel     (csr_sel),
    .eq_x        (eq_x),
    .result_x    (result_x),
    .result_m_raw(result_m_raw),
    .store_m     (store_m)
  );

  result_stage result_stage_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .result_m_raw(result_m_raw),
    .store_m     (store_m),
    .dmem_rdata  (dmem_rdata),
    .dmem_val    (dmem_val_m),
    .dmem_type   (dmem_type_m),
    .wb_sel      (wb_sel),
    .csrw_en     (csrw_en),
    .dmem_val_o  (dmem_val),
    .dmem_type_o (dmem_type),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .result_m    (result_m),
    .result_w    (result_w),
    .rf_wdata    (rf_wdata),
    .out0        (out0),
    .out1        (out1),
    .out2        (out2),
    .out_en      (out_en)
  );

endmodule

//--- testbench/tinyrv1_proc_tb.sv
`timescale 1ns/100ps

`include "tinyrv1_defines.svh"

module tinyrv1_proc_tb;

  localparam int PROG_LEN    = 34;
  localparam int CYCLE_LIMIT = 20 * PROG_LEN + 10;
  // addi x0, x0, 0 returned outside the program
  localparam tinyrv1_pkg::word_t NOP = 32'h0000_0013;

  logic               clk;
  logic               rst_n;
  tinyrv1_pkg::word_t imem_addr;
  tinyrv1_pkg::word_t imem_data;
  logic               dmem_val;
  logic               dmem_type;
  tinyrv1_pkg::word_t dmem_addr;
  tinyrv1_pkg::word_t dmem_wdata;
  tinyrv1_pkg::word_t dmem_rdata;
  tinyrv1_pkg::word_t csr_in0;
  tinyrv1_pkg::word_t csr_in1;
  tinyrv1_pkg::word_t csr_in2;
  tinyrv1_pkg::word_t out0;
  tinyrv1_pkg::word_t out1;
  tinyrv1_pkg::word_t out2;
  logic [2:0]         out_en;

  tinyrv1_pkg::word_t prog [0:PROG_LEN-1];
  tinyrv1_pkg::word_t ram [0:63];
  tinyrv1_pkg::word_t rom_idx;
  tinyrv1_pkg::word_t lcg_state;
  int                 cycles;
  int                 out_pos;
  int                 store_pos;
  int                 out_exp_idx[$];
  tinyrv1_pkg::word_t out_exp_val[$];
  tinyrv1_pkg::word_t store_exp_addr[$];
  tinyrv1_pkg::word_t store_exp_data[$];

  tinyrv1_proc tinyrv1_proc_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .dmem_val  (dmem_val),
    .dmem_type (dmem_type),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_rdata(dmem_rdata),
    .csr_in0   (csr_in0),
    .csr_in1   (csr_in1),
    .csr_in2   (csr_in2),
    .out0      (out0),
    .out1      (out1),
    .out2      (out2),
    .out_en    (out_en)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ==================================================
  // Memory models
  // ==================================================

  assign rom_idx    = (imem_addr - `RESET_PC) >> 2;
  assign imem_data  = (rom_idx < PROG_LEN) ? prog[rom_idx] : NOP;
  // Read data only while a load is requested
  assign dmem_rdata = (dmem_val && !dmem_type) ? ram[dmem_addr[7:2]] : '0;

  function automatic tinyrv1_pkg::word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // One encoder per instruction format
  function automatic tinyrv1_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic tinyrv1_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic tinyrv1_pkg::word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic tinyrv1_pkg::word_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic tinyrv1_pkg::word_t j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic seed_memories();
    int i;
    lcg_state = 32'd30;
    for (i = 0; i < 64; i++) begin
      ram[i] = lcg_next();
    end
    csr_in0 = lcg_next();
    csr_in1 = lcg_next();
    csr_in2 = lcg_next();
  endtask

  // ==================================================
  // Program and expectation tables
  // ==================================================

  task automatic load_program();
    prog[0]  = i_type(12'h5ad, 5'd0, 3'd0, 5'd12, 7'h13);    // marker in x12
    prog[1]  = i_type(12'd13, 5'd0, 3'd0, 5'd1, 7'h13);
    prog[2]  = i_type(12'd7, 5'd1, 3'd0, 5'd2, 7'h13);
    prog[3]  = r_type(7'd0, 5'd1, 5'd2, 5'd3);
    prog[4]  = r_type(7'd1, 5'd2, 5'd3, 5'd4);
    prog[5]  = r_type(7'd0, 5'd2, 5'd4, 5'd5);               // x2 from W
    prog[6]  = i_type(`CSR_OUT0, 5'd5, 3'd1, 5'd0, 7'h73);
    prog[7]  = r_type(7'd1, 5'd3, 5'd5, 5'd6);
    prog[8]  = i_type(`CSR_OUT1, 5'd6, 3'd1, 5'd0, 7'h73);
    // Load-use pairs
    prog[9]  = i_type(12'd12, 5'd0, 3'd2, 5'd8, 7'h03);
    prog[10] = r_type(7'd0, 5'd1, 5'd8, 5'd9);
    prog[11] = i_type(`CSR_OUT2, 5'd9, 3'd1, 5'd0, 7'h73);
    prog[12] = s_type(12'd27, 5'd9, 5'd1);
    prog[13] = i_type(12'd40, 5'd0, 3'd2, 5'd10, 7'h03);
    prog[14] = i_type(`CSR_OUT0, 5'd10, 3'd1, 5'd0, 7'h73);
    // Taken branch skips two marker writes
    prog[15] = b_type(13'd12, 5'd2, 5'd1);
    prog[16] = i_type(`CSR_OUT1, 5'd12, 3'd1, 5'd0, 7'h73);
    prog[17] = i_type(`CSR_OUT2, 5'd12, 3'd1, 5'd0, 7'h73);
    prog[18] = b_type(13'd8, 5'd1, 5'd1);
    prog[19] = i_type(`CSR_OUT1, 5'd2, 3'd1, 5'd0, 7'h73);
    // Jumps
    prog[20] = j_type(21'd8, 5'd13);
    prog[21] = i_type(`CSR_OUT2, 5'd12, 3'd1, 5'd0, 7'h73);
    prog[22] = i_type(`CSR_OUT2, 5'd13, 3'd1, 5'd0, 7'h73);
    prog[23] = i_type(12'd20, 5'd13, 3'd0, 5'd14, 7'h13);
    prog[24] = i_type(12'd0, 5'd14, 3'd0, 5'd0, 7'h67);
    prog[25] = i_type(`CSR_OUT0, 5'd12, 3'd1, 5'd0, 7'h73);
    prog[26] = i_type(`CSR_OUT0, 5'd14, 3'd1, 5'd0, 7'h73);
    // CSR inputs loop back to the outputs
    prog[27] = i_type(`CSR_IN0, 5'd0, 3'd2, 5'd15, 7'h73);
    prog[28] = i_type(`CSR_IN1, 5'd0, 3'd2, 5'd16, 7'h73);
    prog[29] = i_type(`CSR_IN2, 5'd0, 3'd2, 5'd17, 7'h73);
    prog[30] = i_type(`CSR_OUT0, 5'd15, 3'd1, 5'd0, 7'h73);
    prog[31] = i_type(`CSR_OUT1, 5'd16, 3'd1, 5'd0, 7'h73);
    prog[32] = i_type(`CSR_OUT2, 5'd17, 3'd1, 5'd0, 7'h73);
    prog[33] = j_type(21'd0, 5'd0);                          // spin here
  endtask

  task automatic out_entry(input int idx, input tinyrv1_pkg::word_t val);
    out_exp_idx.push_back(idx);
    out_exp_val.push_back(val);
  endtask

  task automatic store_entry(input tinyrv1_pkg::word_t addr, input tinyrv1_pkg::word_t data);
    store_exp_addr.push_back(addr);
    store_exp_data.push_back(data);
  endtask

  task automatic build_expectations();
    tinyrv1_pkg::word_t r1;
    tinyrv1_pkg::word_t r2;
    tinyrv1_pkg::word_t r3;
    tinyrv1_pkg::word_t r5;
    tinyrv1_pkg::word_t r9;
    tinyrv1_pkg::word_t link;
    r1   = 32'd13;
    r2   = r1 + 32'd7;
    r3   = r2 + r1;
    r5   = r3 * r2 + r2;
    r9   = ram[3] + r1;
    link = `RESET_PC + 32'd20 * 4 + 32'd4;
    out_entry(0, r5);
    out_entry(1, r5 * r3);
    out_entry(2, r9);
    out_entry(0, r9);
    out_entry(1, r2);
    out_entry(2, link);
    out_entry(0, link + 32'd20);
    out_entry(0, csr_in0);
    out_entry(1, csr_in1);
    out_entry(2, csr_in2);
    store_entry(r1 + 32'd27, r9);
  endtask

  function automatic logic tables_done();
    return (out_pos == out_exp_val.size()) && (store_pos == store_exp_addr.size());
  endfunction

  // ==================================================
  // Checks
  // ==================================================

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_out(input int which, input tinyrv1_pkg::word_t value);
    if (out_pos >= out_exp_val.size()) begin
      fail_run($sformatf("Unexpected write to out%0d after all outputs were seen", which));
    end else if (out_exp_idx[out_pos] != which) begin
      fail_run($sformatf("Mismatch out_en: expected 0x%0h, got 0x%0h",
                         1 << out_exp_idx[out_pos], 1 << which));
    end else if (value !== out_exp_val[out_pos]) begin
      fail_run($sformatf("Mismatch out%0d: expected 0x%08h, got 0x%08h",
                         which, out_exp_val[out_pos], value));
    end else begin
      out_pos++;
    end
  endtask

  task automatic check_store(input tinyrv1_pkg::word_t addr, input tinyrv1_pkg::word_t data);
    if (store_pos >= store_exp_addr.size()) begin
      fail_run($sformatf("Unexpected store to address 0x%08h", addr));
    end else if (addr !== store_exp_addr[store_pos]) begin
      fail_run($sformatf("Mismatch dmem_addr: expected 0x%08h, got 0x%08h",
                         store_exp_addr[store_pos], addr));
    end else if (data !== store_exp_data[store_pos]) begin
      fail_run($sformatf("Mismatch dmem_wdata: expected 0x%08h, got 0x%08h",
                         store_exp_data[store_pos], data));
    end else begin
      store_pos++;
    end
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
  end

  // Outputs settle by the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (out_en[0]) check_out(0, out0);
      if (out_en[1]) check_out(1, out1);
      if (out_en[2]) check_out(2, out2);
      if (dmem_val && dmem_type) begin
        check_store(dmem_addr, dmem_wdata);
        ram[dmem_addr[7:2]] = dmem_wdata;
      end
    end
  end

  initial begin
    rst_n     = 1'b0;
    cycles    = 0;
    out_pos   = 0;
    store_pos = 0;
    seed_memories();
    load_program();
    build_expectations();
    repeat (10) @(posedge clk);
    #5;
    rst_n = 1'b1;
    while (!tables_done() && cycles < CYCLE_LIMIT) begin
      @(negedge clk);
    end
    // Extra cycles so a stray strobe still shows up
    repeat (10) @(posedge clk);
    if (tables_done()) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      fail_run($sformatf("Timeout after %0d cycles with outputs or stores still pending",
                         cycles));
    end
  end

endmodule

//--- src.f
+incdir+include
hdl/tinyrv1_pkg.sv
hdl/pipe_ctrl.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/tinyrv1_proc.sv
testbench/tinyrv1_proc_tb.sv

//--- Bender.yml
package:
  name: tinyrv1_proc

sources:
  - include_dirs:
      - include
    files:
      - hdl/tinyrv1_pkg.sv
      - hdl/pipe_ctrl.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/result_stage.sv
      - hdl/tinyrv1_proc.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tinyrv1_proc_tb.sv
